// File: dnaPkg.sv
package dnaPkg;

	//////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////
	localparam int dnaBits   = 57;	// factory identifier length
	localparam int countBits = 6;	// bit counter and ones count
	localparam int codeBits  = 64;	// dna + ones + parity

	// gray ordered, one bit flips between neighbours on the main path
	typedef enum logic [3:0] {
		stIdle        = 4'b0000,
		stLoadRead    = 4'b0001,	// raises read
		stLoadClkHigh = 4'b0011,	// load pulse up
		stLoadClkLow  = 4'b0010,	// load pulse down
		stEnterShift  = 4'b0110,	// read off, shift on
		stSample      = 4'b0111,	// capture dnaOut
		stCount       = 4'b0101,	// bump bit counter
		stClkHigh     = 4'b0100,	// shift pulse up
		stClkLow      = 4'b1100,	// shift pulse down, loop or exit
		stFold        = 4'b1101,	// ones count into parity
		stDone        = 4'b1111		// valid, parked
	} seqStateT;

	//////////////////////////////////////////////////
	// code word
	//////////////////////////////////////////////////
	typedef struct packed {
		logic [dnaBits-1:0]   dna;			// first sampled bit at bit 0
		logic [countBits-1:0] onesCount;
		logic                 parity;
	} dnaFieldsT;

	// same 64 bits, whole word or split
	typedef union packed {
		logic [codeBits-1:0] raw;
		dnaFieldsT           fields;
	} dnaCodeU;

	// pins of the identifier port primitive
	typedef struct packed {
		logic read;
		logic shift;
		logic clk;		// software generated port clock
	} portPinsT;

	// sequencer steering for counter and code register
	typedef struct packed {
		logic clear;
		logic sample;
		logic countEn;
		logic fold;
	} seqCtrlT;

endpackage

// File: dnaSequencer.sv
`timescale 1ns/1ps

module dnaSequencer (
	input  logic             CLK4,
	input  logic             rstN,
	input  logic             arm,		// level, low aborts
	input  logic             lastBit,	// from bit counter
	output dnaPkg::portPinsT portPins,
	output dnaPkg::seqCtrlT  ctrl,
	output logic             valid
);

	dnaPkg::seqStateT stateQ;
	dnaPkg::seqStateT nextState;
	dnaPkg::portPinsT pinsNext;
	dnaPkg::seqCtrlT  ctrlNext;
	logic             validNext;

	//////////////////////////////////////////////////
	// next state and pin updates
	//////////////////////////////////////////////////
	// each state acts on the edge that leaves it
	always_comb begin
		nextState = stateQ;
		pinsNext  = portPins;		// pins hold unless touched
		validNext = 1'b0;
		case (stateQ)
			dnaPkg::stIdle: begin
				pinsNext  = '0;
				nextState = dnaPkg::stLoadRead;	// only taken while armed
			end
			dnaPkg::stLoadRead: begin
				pinsNext.read = 1'b1;
				nextState     = dnaPkg::stLoadClkHigh;
			end
			dnaPkg::stLoadClkHigh: begin
				pinsNext.clk = 1'b1;	// port loads on this rise
				nextState    = dnaPkg::stLoadClkLow;
			end
			dnaPkg::stLoadClkLow: begin
				pinsNext.clk = 1'b0;
				nextState    = dnaPkg::stEnterShift;
			end
			dnaPkg::stEnterShift: begin
				pinsNext.read  = 1'b0;	// bit 0 now on dnaOut
				pinsNext.shift = 1'b1;
				nextState      = dnaPkg::stSample;
			end
			// per bit loop, four cycles
			dnaPkg::stSample: begin
				nextState = dnaPkg::stCount;	// code reg captures here
			end
			dnaPkg::stCount: begin
				nextState = dnaPkg::stClkHigh;	// counter bumps here
			end
			dnaPkg::stClkHigh: begin
				pinsNext.clk = 1'b1;	// port shifts right
				nextState    = dnaPkg::stClkLow;
			end
			dnaPkg::stClkLow: begin
				pinsNext.clk = 1'b0;
				if (lastBit) begin
					nextState = dnaPkg::stFold;
				end else begin
					nextState = dnaPkg::stSample;
				end
			end
			dnaPkg::stFold: begin
				nextState = dnaPkg::stDone;
			end
			dnaPkg::stDone: begin
				validNext = 1'b1;
				nextState = dnaPkg::stDone;	// park until arm drops
			end
			default: begin
				pinsNext  = '0;
				nextState = dnaPkg::stIdle;	// stray codes
			end
		endcase

		// arm low wins over everything
		if (!arm) begin
			nextState = dnaPkg::stIdle;
			pinsNext  = '0;
			validNext = 1'b0;
		end
	end

	// steering follows the state being entered
	always_comb begin
		ctrlNext         = '0;
		ctrlNext.clear   = (nextState == dnaPkg::stIdle);
		ctrlNext.sample  = (nextState == dnaPkg::stSample);
		ctrlNext.countEn = (nextState == dnaPkg::stCount);
		ctrlNext.fold    = (nextState == dnaPkg::stFold);
	end

	//////////////////////////////////////////////////
	// registers
	//////////////////////////////////////////////////
	always_ff @(posedge CLK4 or negedge rstN) begin
		if (!rstN) begin
			stateQ       <= dnaPkg::stIdle;
			portPins     <= '0;
			ctrl         <= '0;
			ctrl.clear   <= 1'b1;	// idle holds datapath cleared
			valid        <= 1'b0;
		end else begin
			stateQ   <= nextState;
			portPins <= pinsNext;
			ctrl     <= ctrlNext;
			valid    <= validNext;
		end
	end

endmodule

// File: dnaBitCounter.sv
`timescale 1ns/1ps

module dnaBitCounter (
	input  logic            CLK4,
	input  logic            rstN,
	input  dnaPkg::seqCtrlT ctrl,
	output logic            lastBit	// all identifier bits shifted
);

	logic [dnaPkg::countBits-1:0] countQ;

	// bits taken so far
	always_ff @(posedge CLK4 or negedge rstN) begin
		if (!rstN) begin
			countQ <= '0;
		end else if (ctrl.clear) begin
			countQ <= '0;
		end else if (ctrl.countEn) begin
			countQ <= countQ + dnaPkg::countBits'(1);	// once per bit loop
		end
	end

	// seen by sequencer in the clock low state
	assign lastBit = (countQ == dnaPkg::countBits'(dnaPkg::dnaBits));

endmodule

// File: dnaCodeReg.sv
`timescale 1ns/1ps

module dnaCodeReg (
	input  logic            CLK4,
	input  logic            rstN,
	input  dnaPkg::seqCtrlT ctrl,
	input  logic            dnaOut,	// serial data from the port
	output dnaPkg::dnaCodeU code
);

	dnaPkg::dnaCodeU              codeQ;
	logic [dnaPkg::dnaBits-1:0]   dnaNext;
	logic [dnaPkg::countBits-1:0] onesNext;
	logic                         parityNext;
	logic                         foldParity;

	//////////////////////////////////////////////////
	// per bit update
	//////////////////////////////////////////////////
	// new bit enters at the top, first bit ends in bit 0
	assign dnaNext = {dnaOut, codeQ.fields.dna[dnaPkg::dnaBits-1:1]};

	// ones adder, 57 fits in 6 bits
	assign onesNext = codeQ.fields.onesCount + {{(dnaPkg::countBits-1){1'b0}}, dnaOut};

	assign parityNext = codeQ.fields.parity ^ dnaOut;	// toggles on a one

	// final step folds the count into the data parity
	assign foldParity = codeQ.fields.parity ^ (^codeQ.fields.onesCount);

	//////////////////////////////////////////////////
	// code register
	//////////////////////////////////////////////////
	always_ff @(posedge CLK4 or negedge rstN) begin
		if (!rstN) begin
			codeQ.raw <= '0;
		end else if (ctrl.clear) begin
			codeQ.raw <= '0;			// whole word at once
		end else if (ctrl.sample) begin
			codeQ.fields.dna       <= dnaNext;
			codeQ.fields.onesCount <= onesNext;
			codeQ.fields.parity    <= parityNext;
		end else if (ctrl.fold) begin
			codeQ.fields.parity <= foldParity;	// count stays as is
		end
	end

	// stable from fold until the next clear
	assign code = codeQ;

endmodule

// File: dnaReader.sv
`timescale 1ns/1ps

module dnaReader (
	input  logic             CLK4,
	input  logic             rstN,
	input  logic             arm,		// high starts and holds a read
	input  logic             dnaOut,	// port serial output
	output dnaPkg::portPinsT portPins,	// to the port primitive
	output dnaPkg::dnaCodeU  code,		// identifier, ones count, parity
	output logic             valid		// code complete while armed
);

	dnaPkg::seqCtrlT ctrl;		// sequencer to datapath
	logic            lastBit;	// counter back to sequencer

	//////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////
	dnaSequencer sequencer (
		.CLK4     (CLK4),
		.rstN     (rstN),
		.arm      (arm),
		.lastBit  (lastBit),
		.portPins (portPins),
		.ctrl     (ctrl),
		.valid    (valid)
	);

	// bit count lives apart from the fsm
	dnaBitCounter bitCounter (
		.CLK4    (CLK4),
		.rstN    (rstN),
		.ctrl    (ctrl),
		.lastBit (lastBit)
	);

	//////////////////////////////////////////////////
	// datapath
	//////////////////////////////////////////////////
	dnaCodeReg codeReg (
		.CLK4   (CLK4),
		.rstN   (rstN),
		.ctrl   (ctrl),
		.dnaOut (dnaOut),
		.code   (code)
	);

endmodule

// File: dnaPortModel.sv
`timescale 1ns/1ps

// behavioral stand-in for the identifier port primitive
module dnaPortModel (
	input  logic                       rstN,
	input  dnaPkg::portPinsT           portPins,
	input  logic [dnaPkg::dnaBits-1:0] factoryId,	// value the port hands out
	output logic                       dnaOut
);

	logic                       portClk;
	logic [dnaPkg::dnaBits-1:0] shiftQ;

	assign portClk = portPins.clk;	// software clock from the reader

	// read wins over shift when both are up
	always_ff @(posedge portClk or negedge rstN) begin
		if (!rstN) begin
			shiftQ <= '0;
		end else if (portPins.read) begin
			shiftQ <= factoryId;	// parallel load
		end else if (portPins.shift) begin
			shiftQ <= {1'b0, shiftQ[dnaPkg::dnaBits-1:1]};	// lsb first out
		end
	end

	assign dnaOut = shiftQ[0];

endmodule

// File: dnaReaderTb.sv
`timescale 1ns/1ps

module dnaReaderTb;

	// arm edge to valid: idle exit, load, four per bit, fold, done
	localparam int readLatency = 1 + 4 + 4 * dnaPkg::dnaBits + 2;
	localparam int readLimit   = 300;	// per read wait bound
	localparam int cycleLimit  = 4000;	// about 12 reads of 240 plus margin

	logic                       CLK4;
	logic                       rstN;
	logic                       arm;
	logic                       dnaOut;
	logic [dnaPkg::dnaBits-1:0] modelId;
	dnaPkg::portPinsT           portPins;
	dnaPkg::dnaCodeU            code;
	logic                       valid;

	logic [31:0] lfsrState;
	int          testErrors;
	int          passCount;
	int          failCount;
	int          cycleCount;

	dnaReader dnaReader_i (
		.CLK4     (CLK4),
		.rstN     (rstN),
		.arm      (arm),
		.dnaOut   (dnaOut),
		.portPins (portPins),
		.code     (code),
		.valid    (valid)
	);

	dnaPortModel portModel (
		.rstN      (rstN),
		.portPins  (portPins),
		.factoryId (modelId),
		.dnaOut    (dnaOut)
	);

	initial begin
		CLK4 = 1'b0;
		forever #5 CLK4 = ~CLK4;
	end

	//////////////////////////////////////////////////
	// reference and stimulus helpers
	//////////////////////////////////////////////////
	// galois form, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// one lfsr step per identifier bit
	task automatic nextRandomId(output logic [dnaPkg::dnaBits-1:0] id);
		for (int i = 0; i < dnaPkg::dnaBits; i++) begin
			lfsrState = lfsrStep(lfsrState);
			id[i]     = lfsrState[0];
		end
	endtask

	// popcount, then parity over data bits and count bits
	function automatic dnaPkg::dnaCodeU expectedCode(input logic [dnaPkg::dnaBits-1:0] id);
		dnaPkg::dnaCodeU              c;
		logic [dnaPkg::countBits-1:0] ones;
		logic                         par;
		ones = '0;
		par  = 1'b0;
		for (int i = 0; i < dnaPkg::dnaBits; i++) begin
			ones = ones + dnaPkg::countBits'(id[i]);
			par  = par ^ id[i];
		end
		for (int i = 0; i < dnaPkg::countBits; i++) begin
			par = par ^ ones[i];
		end
		c.fields.dna       = id;
		c.fields.onesCount = ones;
		c.fields.parity    = par;
		return c;
	endfunction

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////
	task automatic checkCode(input string testName, input dnaPkg::dnaCodeU expected,
			input dnaPkg::dnaCodeU actual);
		if (actual.raw !== expected.raw) begin
			$display("FAILED %s code: expected %016h actual %016h",
				testName, expected.raw, actual.raw);
			testErrors++;
		end
	endtask

	task automatic checkLevel(input string testName, input string what, input logic expected,
			input logic actual);
		if (actual !== expected) begin
			$display("FAILED %s %s: expected %b actual %b", testName, what, expected, actual);
			testErrors++;
		end
	endtask

	task automatic checkPins(input string testName, input dnaPkg::portPinsT expected,
			input dnaPkg::portPinsT actual);
		if (actual !== expected) begin
			$display("FAILED %s port pins: expected %03b actual %03b", testName, expected, actual);
			testErrors++;
		end
	endtask

	task automatic checkCycles(input string testName, input int expected, input int actual);
		if (actual != expected) begin
			$display("FAILED %s latency: expected %0d actual %0d", testName, expected, actual);
			testErrors++;
		end
	endtask

	task automatic endTest(input string testName);
		if (testErrors == 0) begin
			passCount++;
			$display("%s: ok", testName);
		end else begin
			failCount++;
			$display("%s: %0d errors", testName, testErrors);
		end
		testErrors = 0;
	endtask

	//////////////////////////////////////////////////
	// read sequencing, called on a falling edge
	//////////////////////////////////////////////////
	task automatic readId(input string testName, input logic [dnaPkg::dnaBits-1:0] id,
			output int cycles);
		cycles  = 0;
		modelId = id;
		arm     = 1'b1;
		while (valid !== 1'b1 && cycles < readLimit) begin
			@(negedge CLK4);
			cycles++;
		end
		if (valid !== 1'b1) begin
			$display("%s: valid never rose within %0d cycles of arm", testName, readLimit);
			testErrors++;
		end
	endtask

	task automatic dropArm(input string testName);
		dnaPkg::dnaCodeU zero;
		zero.raw = '0;
		arm      = 1'b0;
		@(negedge CLK4);
		checkLevel(testName, "valid after arm drop", 1'b0, valid);
		@(negedge CLK4);	// clear has reached the code register
		checkCode(testName, zero, code);
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////
	task automatic resetIdle();
		dnaPkg::dnaCodeU zero;
		zero.raw = '0;
		@(negedge CLK4);
		checkLevel("resetIdle", "valid", 1'b0, valid);
		checkPins("resetIdle", '0, portPins);
		checkCode("resetIdle", zero, code);
		endTest("resetIdle");
	endtask

	task automatic knownId();
		logic [dnaPkg::dnaBits-1:0] id;
		int                         cycles;
		id = 57'h1_2345_6789_ABCD_EF;
		readId("knownId", id, cycles);
		checkCycles("knownId", readLatency, cycles);
		checkCode("knownId", expectedCode(id), code);
		dropArm("knownId");
		endTest("knownId");
	endtask

	task automatic edgeIds();
		logic [dnaPkg::dnaBits-1:0] id;
		int                         cycles;
		id = '0;	// count 0, parity 0
		readId("edgeIds", id, cycles);
		checkCode("edgeIds", expectedCode(id), code);
		dropArm("edgeIds");
		id = '1;	// count 57, folded parity
		readId("edgeIds", id, cycles);
		checkCode("edgeIds", expectedCode(id), code);
		dropArm("edgeIds");
		endTest("edgeIds");
	endtask

	task automatic randomIds();
		logic [dnaPkg::dnaBits-1:0] id;
		int                         cycles;
		for (int n = 0; n < 5; n++) begin
			nextRandomId(id);
			readId("randomIds", id, cycles);
			checkCode("randomIds", expectedCode(id), code);
			dropArm("randomIds");
		end
		endTest("randomIds");
	endtask

	task automatic abortRearm();
		logic [dnaPkg::dnaBits-1:0] id;
		int                         cycles;
		logic                       sawValid;
		sawValid = 1'b0;
		nextRandomId(id);
		modelId = id;
		arm     = 1'b1;
		repeat (100) begin
			@(negedge CLK4);
			sawValid = sawValid | valid;	// mid shift, never complete
		end
		checkLevel("abortRearm", "valid during partial read", 1'b0, sawValid);
		dropArm("abortRearm");
		nextRandomId(id);	// fresh identifier for the second try
		readId("abortRearm", id, cycles);
		checkCycles("abortRearm", readLatency, cycles);
		checkCode("abortRearm", expectedCode(id), code);
		dropArm("abortRearm");
		endTest("abortRearm");
	endtask

	task automatic holdStable();
		logic [dnaPkg::dnaBits-1:0] id;
		int                         cycles;
		dnaPkg::dnaCodeU            snap;
		logic                       validDropped;
		logic                       codeMoved;
		logic                       clkMoved;
		validDropped = 1'b0;
		codeMoved    = 1'b0;
		clkMoved     = 1'b0;
		id = 57'h0F0_F0F0_5A5A_3C3C;
		readId("holdStable", id, cycles);
		snap = code;
		repeat (50) begin
			@(negedge CLK4);
			if (valid !== 1'b1) validDropped = 1'b1;
			if (code.raw !== snap.raw) codeMoved = 1'b1;
			if (portPins.clk !== 1'b0) clkMoved = 1'b1;	// port parked
		end
		checkLevel("holdStable", "valid dropped", 1'b0, validDropped);
		checkLevel("holdStable", "code moved", 1'b0, codeMoved);
		checkLevel("holdStable", "port clk pulsed", 1'b0, clkMoved);
		checkCode("holdStable", expectedCode(id), code);
		dropArm("holdStable");
		endTest("holdStable");
	endtask

	//////////////////////////////////////////////////
	// main sequence and watchdog
	//////////////////////////////////////////////////
	initial begin
		rstN       = 1'b0;
		arm        = 1'b0;
		modelId    = '0;
		lfsrState  = 32'h110;
		testErrors = 0;
		passCount  = 0;
		failCount  = 0;
		repeat (8) @(posedge CLK4);
		@(negedge CLK4);
		rstN = 1'b1;
		resetIdle();
		knownId();
		edgeIds();
		randomIds();
		abortRearm();
		holdStable();
		$display("tests ok %0d, tests with errors %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < cycleLimit) begin
			@(posedge CLK4);
			cycleCount++;
		end
		$display("timeout: tests still running after %0d cycles", cycleLimit);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: filelist.f
dnaPkg.sv
dnaSequencer.sv
dnaBitCounter.sv
dnaCodeReg.sv
dnaReader.sv
dnaPortModel.sv
dnaReaderTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = dnaReaderTb
FILELIST  = filelist.f
OBJDIR    = obj_dir
SIMBIN    = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIMBIN)

$(SIMBIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIMBIN)
	@out="$$(./$(SIMBIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJDIR)
